//--- common/rvExecPkg.sv
// Shared types and constants for the RV32I decode/execute unit.
// Base integer set only. Funct7 value 1 (M extension) decodes as illegal.
// Enum encodings of opcodeT follow the RV32I major opcode field directly.

package rvExecPkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // funct7 values accepted on R-type and shift-immediate forms
  localparam logic [6:0] FUNCT7_BASE = 7'h00;
  localparam logic [6:0] FUNCT7_ALT  = 7'h20; // sub, sra, srai

  // major opcodes, values are the raw instruction bits 6:0
  typedef enum logic [6:0] {
    opCompute  = 7'b0110011,
    opImm      = 7'b0010011,
    opBranch   = 7'b1100011,
    opLoad     = 7'b0000011,
    opStore    = 7'b0100011,
    opJal      = 7'b1101111,
    opJalr     = 7'b1100111,
    opLui      = 7'b0110111,
    opAuipc    = 7'b0010111
  } opcodeT;

  // immediate formats
  typedef enum logic [2:0] {
    immNone  = 3'd0,
    immI     = 3'd1,
    immS     = 3'd2,
    immB     = 3'd3,
    immU     = 3'd4,
    immJ     = 3'd5,
    immShamt = 3'd6  // shift amount in bits 24:20
  } immKindT;

  // source of rdData
  typedef enum logic [1:0] {
    wbAlu  = 2'd0,
    wbPc4  = 2'd1,
    wbImm  = 2'd2,
    wbNone = 2'd3  // loads, stores, branches
  } wbSelT;

  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluSub  = 4'd1,
    aluSll  = 4'd2,
    aluSlt  = 4'd3,
    aluSltu = 4'd4,
    aluXor  = 4'd5,
    aluSrl  = 4'd6,
    aluSra  = 4'd7,
    aluOr   = 4'd8,
    aluAnd  = 4'd9
  } aluOpT;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    memByte = 2'd0,
    memHalf = 2'd1,
    memWord = 2'd2
  } memSizeT;

  // listed in priority order, illegal first
  typedef enum logic [1:0] {
    trapNone      = 2'd0,
    trapIllegal   = 2'd1,
    trapMisTarget = 2'd2,
    trapMisMem    = 2'd3
  } trapCauseT;

endpackage

//--- hw/execute/aluCore.sv
// Combinational base-integer ALU, no M extension.
// Shifts use only the low 5 bits of opB, compares return 1 or 0.

`timescale 1ns/1ps

module aluCore import rvExecPkg::*; (
  input  aluOpT           aluOp,
  input  logic [XLEN-1:0] opA,
  input  logic [XLEN-1:0] opB,
  output logic [XLEN-1:0] result
);

  logic [4:0] shamt;
  logic       ltSigned;
  logic       ltUnsigned;

  assign shamt      = opB[4:0];
  assign ltSigned   = $signed(opA) < $signed(opB);
  assign ltUnsigned = opA < opB;

  always_comb begin
    case (aluOp)
      aluAdd: begin
        result = opA + opB; // also address and target sums
      end
      aluSub: begin
        result = opA - opB;
      end
      aluSll: begin
        result = opA << shamt;
      end
      aluSlt: begin
        result = {{(XLEN-1){1'b0}}, ltSigned};
      end
      aluSltu: begin
        result = {{(XLEN-1){1'b0}}, ltUnsigned};
      end
      aluXor: begin
        result = opA ^ opB;
      end
      aluSrl: begin
        result = opA >> shamt;
      end
      aluSra: begin
        result = $unsigned($signed(opA) >>> shamt); // sign fill
      end
      aluOr: begin
        result = opA | opB;
      end
      aluAnd: begin
        result = opA & opB;
      end
      default: begin
        result = opA + opB; // unused encodings
      end
    endcase
  end

endmodule

//--- hw/execute/executeStage.sv
// Output stage: ALU, branch decision, next PC, memory address and traps.
// A trap clears rdWrite, memRead and memWrite and holds nextPc at the own PC.
// Loads only issue an address here; load data never comes back.

`timescale 1ns/1ps

module executeStage import rvExecPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  decValid,
  output logic                  execReady,
  input  opcodeT                decOpcode,
  input  aluOpT                 decAluOp,
  input  wbSelT                 decWbSel,
  input  logic [XLEN-1:0]       decImm,
  input  logic [XLEN-1:0]       decPc,
  input  logic [XLEN-1:0]       decRs1,
  input  logic [XLEN-1:0]       decRs2,
  input  logic [REG_ADDR_W-1:0] decRd,
  input  logic [2:0]            decFunct3,
  input  memSizeT               decMemSize,
  input  logic                  decIllegal,
  output logic                  outValid,
  input  logic                  outReady,
  output logic [REG_ADDR_W-1:0] rdAddr,
  output logic                  rdWrite,
  output logic [XLEN-1:0]       rdData,
  output logic [XLEN-1:0]       nextPc,
  output logic                  memRead,
  output logic                  memWrite,
  output logic [XLEN-1:0]       memAddr,
  output memSizeT               memSize,
  output logic [XLEN-1:0]       storeData,
  output trapCauseT             trapCause
);

  logic            isBranch, isJal, isJalr, isLoad, isStore;
  logic            brCond, taken, misMem, noTrap, accept;
  logic [XLEN-1:0] opA, opB, aluResult, pcPlus4, target, wbData;
  trapCauseT       trap;

  assign isBranch = decOpcode == opBranch;
  assign isJal    = decOpcode == opJal;
  assign isJalr   = decOpcode == opJalr;
  assign isLoad   = decOpcode == opLoad;
  assign isStore  = decOpcode == opStore;

  assign opA = (isBranch || isJal || decOpcode == opAuipc) ? decPc : decRs1;
  assign opB = (decOpcode == opCompute) ? decRs2 : decImm;

  aluCore aluCore_inst (
    .aluOp  (decAluOp),
    .opA    (opA),
    .opB    (opB),
    .result (aluResult)
  );

  always_comb begin
    case (decFunct3)
      3'd0:    brCond = decRs1 == decRs2;
      3'd1:    brCond = decRs1 != decRs2;
      3'd4:    brCond = $signed(decRs1) < $signed(decRs2);
      3'd5:    brCond = $signed(decRs1) >= $signed(decRs2);
      3'd6:    brCond = decRs1 < decRs2;
      3'd7:    brCond = decRs1 >= decRs2;
      default: brCond = 1'b0; // already flagged illegal
    endcase
  end

  assign taken   = isJal || isJalr || (isBranch && brCond);
  assign target  = isJalr ? {aluResult[XLEN-1:1], 1'b0} : aluResult;
  assign pcPlus4 = decPc + 32'd4;

  // size check on the load/store address
  always_comb begin
    misMem = 1'b0;
    if (isLoad || isStore) begin
      case (decMemSize)
        memHalf: misMem = aluResult[0];
        memWord: misMem = aluResult[1:0] != 2'b00;
        default: misMem = 1'b0;
      endcase
    end
  end

  always_comb begin
    if (decIllegal) trap = trapIllegal;
    else if (taken && target[1:0] != 2'b00) trap = trapMisTarget;
    else if (misMem) trap = trapMisMem;
    else trap = trapNone;
  end

  assign noTrap = trap == trapNone;

  always_comb begin
    case (decWbSel)
      wbAlu:   wbData = aluResult;
      wbPc4:   wbData = pcPlus4;
      wbImm:   wbData = decImm; // lui
      default: wbData = '0;
    endcase
  end

  assign execReady = !outValid || outReady;
  assign accept    = decValid && execReady;

  always_ff @(posedge clk) begin
    if (reset) outValid <= 1'b0;
    else if (accept) outValid <= 1'b1;
    else if (outReady) outValid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdAddr    <= decRd;
      rdWrite   <= noTrap && decWbSel != wbNone && decRd != '0;
      rdData    <= wbData;
      nextPc    <= !noTrap ? decPc : (taken ? target : pcPlus4);
      memRead   <= noTrap && isLoad;
      memWrite  <= noTrap && isStore;
      memAddr   <= aluResult;
      memSize   <= decMemSize;
      storeData <= decRs2;
      trapCause <= trap;
    end
  end

  holdStable: assert property (@(posedge clk) disable iff (reset)
    outValid && !outReady |=> outValid && $stable({rdAddr, rdWrite, rdData, nextPc,
      memRead, memWrite, memAddr, memSize, storeData, trapCause}));

  memDirExcl: assert property (@(posedge clk) disable iff (reset)
    outValid |-> !(memRead && memWrite));

endmodule

//--- hw/decode/instDecoder.sv
// Input stage: decodes one RV32I word per transfer and registers the result.
// Register and PC values pass through untouched for the execute stage.
// inReady stays high while the register is empty or being drained.

`timescale 1ns/1ps

module instDecoder import rvExecPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  inValid,
  output logic                  inReady,
  input  logic [XLEN-1:0]       instWord,
  input  logic [XLEN-1:0]       pc,
  input  logic [XLEN-1:0]       rs1Data,
  input  logic [XLEN-1:0]       rs2Data,
  output logic                  decValid,
  input  logic                  execReady,
  output opcodeT                decOpcode,
  output aluOpT                 decAluOp,
  output wbSelT                 decWbSel,
  output logic [XLEN-1:0]       decImm,
  output logic [XLEN-1:0]       decPc,
  output logic [XLEN-1:0]       decRs1,
  output logic [XLEN-1:0]       decRs2,
  output logic [REG_ADDR_W-1:0] decRd,
  output logic [2:0]            decFunct3,
  output memSizeT               decMemSize,
  output logic                  decIllegal
);

  opcodeT          opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  immKindT         immKind;
  aluOpT           fnOp;
  aluOpT           aluOp;
  wbSelT           wbSel;
  memSizeT         memSize;
  logic            illegal;
  logic [XLEN-1:0] imm;
  logic            load;

  assign opcode = opcodeT'(instWord[6:0]); // may hold a non-member value
  assign funct3 = instWord[14:12];
  assign funct7 = instWord[31:25];

  // funct3 to ALU op, shared by R and I forms
  always_comb begin
    case (funct3)
      3'd0:    fnOp = aluAdd;
      3'd1:    fnOp = aluSll;
      3'd2:    fnOp = aluSlt;
      3'd3:    fnOp = aluSltu;
      3'd4:    fnOp = aluXor;
      3'd5:    fnOp = aluSrl;
      3'd6:    fnOp = aluOr;
      default: fnOp = aluAnd;
    endcase
  end

  always_comb begin
    immKind = immNone;
    aluOp   = aluAdd; // address and target math
    wbSel   = wbNone;
    memSize = memWord;
    illegal = 1'b0;
    case (opcode)
      opCompute: begin
        wbSel = wbAlu;
        aluOp = fnOp;
        if (funct7 == FUNCT7_ALT && funct3 == 3'd0) aluOp = aluSub;
        else if (funct7 == FUNCT7_ALT && funct3 == 3'd5) aluOp = aluSra;
        else if (funct7 != FUNCT7_BASE) illegal = 1'b1; // includes M extension
      end
      opImm: begin
        wbSel   = wbAlu;
        aluOp   = fnOp;
        immKind = immI;
        if (funct3 == 3'd1) begin
          immKind = immShamt;
          illegal = (funct7 != FUNCT7_BASE);
        end else if (funct3 == 3'd5) begin
          immKind = immShamt;
          if (funct7 == FUNCT7_ALT) aluOp = aluSra;
          else if (funct7 != FUNCT7_BASE) illegal = 1'b1;
        end
      end
      opBranch: begin
        immKind = immB;
        illegal = (funct3 == 3'd2) || (funct3 == 3'd3);
      end
      opLoad: begin
        immKind = immI;
        case (funct3)
          3'd0, 3'd4: memSize = memByte; // lb, lbu
          3'd1, 3'd5: memSize = memHalf; // lh, lhu
          3'd2:       memSize = memWord;
          default:    illegal = 1'b1;
        endcase
      end
      opStore: begin
        immKind = immS;
        case (funct3)
          3'd0:    memSize = memByte;
          3'd1:    memSize = memHalf;
          3'd2:    memSize = memWord;
          default: illegal = 1'b1;
        endcase
      end
      opJal:   begin immKind = immJ; wbSel = wbPc4; end
      opJalr:  begin immKind = immI; wbSel = wbPc4; end
      opLui:   begin immKind = immU; wbSel = wbImm; end
      opAuipc: begin immKind = immU; wbSel = wbAlu; end
      default: illegal = 1'b1; // unknown opcode
    endcase
  end

  // immediate generator
  always_comb begin
    case (immKind)
      immI:     imm = {{20{instWord[31]}}, instWord[31:20]};
      immS:     imm = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};
      immB:     imm = {{19{instWord[31]}}, instWord[31], instWord[7], instWord[30:25],
                       instWord[11:8], 1'b0};
      immU:     imm = {instWord[31:12], 12'b0};
      immJ:     imm = {{11{instWord[31]}}, instWord[31], instWord[19:12], instWord[20],
                       instWord[30:21], 1'b0};
      immShamt: imm = {27'b0, instWord[24:20]};
      default:  imm = '0;
    endcase
  end

  assign inReady = !decValid || execReady;
  assign load    = inValid && inReady;

  always_ff @(posedge clk) begin
    if (reset) decValid <= 1'b0;
    else if (load) decValid <= 1'b1;
    else if (execReady) decValid <= 1'b0; // drained by execute stage
  end

  always_ff @(posedge clk) begin
    if (load) begin
      decOpcode  <= opcode;
      decAluOp   <= aluOp;
      decWbSel   <= wbSel;
      decImm     <= imm;
      decPc      <= pc;
      decRs1     <= rs1Data;
      decRs2     <= rs2Data;
      decRd      <= instWord[11:7];
      decFunct3  <= funct3;
      decMemSize <= memSize;
      decIllegal <= illegal;
    end
  end

  legalOpcode: assert property (@(posedge clk) disable iff (reset)
    decValid && !decIllegal |-> decOpcode inside {opCompute, opImm, opBranch, opLoad,
                                                  opStore, opJal, opJalr, opLui, opAuipc});

endmodule

//--- hw/rvExecUnit.sv
// RV32I decode and execute unit, two registered stages.
// Latency is 2 cycles from input transfer to output with outReady high.
// No register file, forwarding or load data path inside.

`timescale 1ns/1ps

module rvExecUnit import rvExecPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  inValid,
  output logic                  inReady,
  input  logic [XLEN-1:0]       instWord,
  input  logic [XLEN-1:0]       pc,
  input  logic [XLEN-1:0]       rs1Data,
  input  logic [XLEN-1:0]       rs2Data,
  output logic                  outValid,
  input  logic                  outReady,
  output logic [REG_ADDR_W-1:0] rdAddr,
  output logic                  rdWrite,
  output logic [XLEN-1:0]       rdData,
  output logic [XLEN-1:0]       nextPc,
  output logic                  memRead,
  output logic                  memWrite,
  output logic [XLEN-1:0]       memAddr,
  output memSizeT               memSize,
  output logic [XLEN-1:0]       storeData,
  output trapCauseT             trapCause
);

  logic                  decValid, execReady;
  opcodeT                decOpcode;
  aluOpT                 decAluOp;
  wbSelT                 decWbSel;
  logic [XLEN-1:0]       decImm, decPc, decRs1, decRs2;
  logic [REG_ADDR_W-1:0] decRd;
  logic [2:0]            decFunct3;
  memSizeT               decMemSize;
  logic                  decIllegal;

  instDecoder instDecoder_inst (
    .clk        (clk),
    .reset      (reset),
    .inValid    (inValid),
    .inReady    (inReady),
    .instWord   (instWord),
    .pc         (pc),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .decValid   (decValid),
    .execReady  (execReady),
    .decOpcode  (decOpcode),
    .decAluOp   (decAluOp),
    .decWbSel   (decWbSel),
    .decImm     (decImm),
    .decPc      (decPc),
    .decRs1     (decRs1),
    .decRs2     (decRs2),
    .decRd      (decRd),
    .decFunct3  (decFunct3),
    .decMemSize (decMemSize),
    .decIllegal (decIllegal)
  );

  executeStage executeStage_inst (
    .clk        (clk),
    .reset      (reset),
    .decValid   (decValid),
    .execReady  (execReady),
    .decOpcode  (decOpcode),
    .decAluOp   (decAluOp),
    .decWbSel   (decWbSel),
    .decImm     (decImm),
    .decPc      (decPc),
    .decRs1     (decRs1),
    .decRs2     (decRs2),
    .decRd      (decRd),
    .decFunct3  (decFunct3),
    .decMemSize (decMemSize),
    .decIllegal (decIllegal),
    .outValid   (outValid),
    .outReady   (outReady),
    .rdAddr     (rdAddr),
    .rdWrite    (rdWrite),
    .rdData     (rdData),
    .nextPc     (nextPc),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .memAddr    (memAddr),
    .memSize    (memSize),
    .storeData  (storeData),
    .trapCause  (trapCause)
  );

endmodule

//--- tb/rvExecVectors.svh
// One row of stimulus and expected results per instruction for rvExecUnit.
// Row layout is instWord pc rs1 rs2 rd rdWrite rdData nextPc {memRead,memWrite} memAddr
// memSize trap. memSize 0 byte 1 half 2 word, trap 0 none 1 illegal 2 mis-target 3 mis-mem
// rd and rdData count only when rdWrite is set, memAddr and memSize only on a memory access

typedef struct packed {
  logic [31:0] instWord;
  logic [31:0] pc;
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic [4:0]  rd;
  logic        rdWrite;
  logic [31:0] rdData;
  logic [31:0] nextPc;
  logic [1:0]  memRw;   // {read, write}
  logic [31:0] memAddr;
  logic [1:0]  memSize;
  logic [1:0]  trap;
} vecRowT;

localparam int NUM_VEC = 42;

localparam vecRowT vecTable [NUM_VEC] = '{
  {32'h002081B3, 32'h100, 32'h5, 32'h7,                  // add
   5'd3, 1'b1, 32'h0000000C, 32'h104, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h40208233, 32'h100, 32'h5, 32'h7,                  // sub with negative result
   5'd4, 1'b1, 32'hFFFFFFFE, 32'h104, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h4020D2B3, 32'h100, 32'h80000010, 32'h4,           // sra on negative value
   5'd5, 1'b1, 32'hF8000001, 32'h104, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020A333, 32'h100, 32'hFFFFFFFF, 32'h1,           // slt -1 < 1
   5'd6, 1'b1, 32'h00000001, 32'h104, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020B3B3, 32'h100, 32'hFFFFFFFF, 32'h1,           // sltu on the same operands
   5'd7, 1'b1, 32'h00000000, 32'h104, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h00209433, 32'h100, 32'h1, 32'h25,                 // sll by 37 uses only 5
   5'd8, 1'b1, 32'h00000020, 32'h104, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020D4B3, 32'h100, 32'h80000000, 32'h21,          // srl by 33 uses only 1
   5'd9, 1'b1, 32'h40000000, 32'h104, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020F533, 32'h100, 32'hF0F0, 32'hFF00,            // and
   5'd10, 1'b1, 32'h0000F000, 32'h104, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h00208033, 32'h100, 32'h5, 32'h7,                  // add to x0
   5'd0, 1'b0, 32'h0, 32'h104, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'hFFD08693, 32'h104, 32'hA, 32'h0,                  // addi -3
   5'd13, 1'b1, 32'h00000007, 32'h108, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h41F0D713, 32'h108, 32'h80000000, 32'h0,           // srai 31
   5'd14, 1'b1, 32'hFFFFFFFF, 32'h10C, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'hFFF0B793, 32'h10C, 32'h5, 32'h0,                  // sltiu against -1
   5'd15, 1'b1, 32'h00000001, 32'h110, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h00409893, 32'h110, 32'hF, 32'h0,                  // slli 4
   5'd17, 1'b1, 32'h000000F0, 32'h114, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h12345937, 32'h200, 32'h0, 32'h0,                  // lui
   5'd18, 1'b1, 32'h12345000, 32'h204, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h00001997, 32'h200, 32'h0, 32'h0,                  // auipc
   5'd19, 1'b1, 32'h00001200, 32'h204, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h010000EF, 32'h300, 32'h0, 32'h0,                  // jal +16
   5'd1, 1'b1, 32'h00000304, 32'h310, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h001082E7, 32'h500, 32'h400, 32'h0,                // jalr clears bit 0
   5'd5, 1'b1, 32'h00000504, 32'h400, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h00208463, 32'h600, 32'h5, 32'h5,                  // beq taken
   5'd0, 1'b0, 32'h0, 32'h608, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h00209463, 32'h600, 32'h5, 32'h5,                  // bne not taken
   5'd0, 1'b0, 32'h0, 32'h604, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020C463, 32'h600, 32'hFFFFFFFF, 32'h1,           // blt taken
   5'd0, 1'b0, 32'h0, 32'h608, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020E463, 32'h600, 32'hFFFFFFFF, 32'h1,           // bltu not taken
   5'd0, 1'b0, 32'h0, 32'h604, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020D463, 32'h600, 32'hFFFFFFFF, 32'h1,           // bge not taken
   5'd0, 1'b0, 32'h0, 32'h604, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020F463, 32'h600, 32'hFFFFFFFF, 32'h1,           // bgeu taken
   5'd0, 1'b0, 32'h0, 32'h608, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h00208463, 32'h600, 32'h5, 32'h6,                  // beq not taken
   5'd0, 1'b0, 32'h0, 32'h604, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h00209463, 32'h600, 32'h5, 32'h6,                  // bne taken
   5'd0, 1'b0, 32'h0, 32'h608, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020C463, 32'h600, 32'h1, 32'hFFFFFFFF,           // blt 1 < -1 not taken
   5'd0, 1'b0, 32'h0, 32'h604, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020E463, 32'h600, 32'h1, 32'hFFFFFFFF,           // bltu taken
   5'd0, 1'b0, 32'h0, 32'h608, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020D463, 32'h600, 32'h1, 32'hFFFFFFFF,           // bge 1 >= -1 taken
   5'd0, 1'b0, 32'h0, 32'h608, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h0020F463, 32'h600, 32'h1, 32'hFFFFFFFF,           // bgeu not taken
   5'd0, 1'b0, 32'h0, 32'h604, 2'b00, 32'h0, 2'd0, 2'd0},
  {32'h00208363, 32'h600, 32'h5, 32'h5,                  // beq taken to pc+6
   5'd0, 1'b0, 32'h0, 32'h600, 2'b00, 32'h0, 2'd0, 2'd2},
  {32'h0080AA03, 32'h700, 32'h1000, 32'h0,               // lw 8
   5'd0, 1'b0, 32'h0, 32'h704, 2'b10, 32'h1008, 2'd2, 2'd0},
  {32'hFFF0CB03, 32'h700, 32'h1000, 32'h0,               // lbu -1
   5'd0, 1'b0, 32'h0, 32'h704, 2'b10, 32'h0FFF, 2'd0, 2'd0},
  {32'h00109A83, 32'h700, 32'h1000, 32'h0,               // lh at odd address
   5'd0, 1'b0, 32'h0, 32'h700, 2'b00, 32'h0, 2'd0, 2'd3},
  {32'h0020AA03, 32'h700, 32'h1000, 32'h0,               // lw at +2
   5'd0, 1'b0, 32'h0, 32'h700, 2'b00, 32'h0, 2'd0, 2'd3},
  {32'h0020A223, 32'h800, 32'h2000, 32'hDEADBEEF,        // sw 4
   5'd0, 1'b0, 32'h0, 32'h804, 2'b01, 32'h2004, 2'd2, 2'd0},
  {32'hFE209F23, 32'h800, 32'h2000, 32'h1234,            // sh -2
   5'd0, 1'b0, 32'h0, 32'h804, 2'b01, 32'h1FFE, 2'd1, 2'd0},
  {32'h002081A3, 32'h800, 32'h2000, 32'hAB,              // sb 3
   5'd0, 1'b0, 32'h0, 32'h804, 2'b01, 32'h2003, 2'd0, 2'd0},
  {32'h0000000B, 32'h900, 32'h0, 32'h0,                  // unknown opcode
   5'd0, 1'b0, 32'h0, 32'h900, 2'b00, 32'h0, 2'd0, 2'd1},
  {32'h0080BA03, 32'h900, 32'h1000, 32'h0,               // load funct3 3
   5'd0, 1'b0, 32'h0, 32'h900, 2'b00, 32'h0, 2'd0, 2'd1},
  {32'h020081B3, 32'h900, 32'h5, 32'h7,                  // mul
   5'd0, 1'b0, 32'h0, 32'h900, 2'b00, 32'h0, 2'd0, 2'd1},
  {32'h40409893, 32'h900, 32'hF, 32'h0,                  // slli with funct7 0x20
   5'd0, 1'b0, 32'h0, 32'h900, 2'b00, 32'h0, 2'd0, 2'd1},
  {32'h0020A463, 32'h900, 32'h5, 32'h5,                  // branch funct3 2
   5'd0, 1'b0, 32'h0, 32'h900, 2'b00, 32'h0, 2'd0, 2'd1}
};

//--- tb/rvExecChecker.sv
// Watches both handshakes of rvExecUnit and compares each result with the table.
// Samples on the falling edge, when all signals are settled.
// Latency is checked as 2 cycles whenever outReady stayed high after the input.

`timescale 1ns/1ps

module rvExecChecker import rvExecPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  inValid,
  input  logic                  inReady,
  input  logic                  outValid,
  input  logic                  outReady,
  input  logic [REG_ADDR_W-1:0] rdAddr,
  input  logic                  rdWrite,
  input  logic [XLEN-1:0]       rdData,
  input  logic [XLEN-1:0]       nextPc,
  input  logic                  memRead,
  input  logic                  memWrite,
  input  logic [XLEN-1:0]       memAddr,
  input  memSizeT               memSize,
  input  logic [XLEN-1:0]       storeData,
  input  trapCauseT             trapCause,
  output int                    seenCount,
  output int                    valueErrors,
  output int                    flowErrors
);

  `include "rvExecVectors.svh"

  int           cycle;
  int           lastLow;    // last cycle with outReady low
  int           startCycle;
  int           inCycles [$];
  logic         prevHold;
  logic [139:0] prevOut;
  logic [139:0] outBus;

  assign outBus = {rdAddr, rdWrite, rdData, nextPc, memRead, memWrite, memAddr, memSize,
                   storeData, trapCause};

  task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t: entry %0d field %s is %h, expected %h", $time, seenCount, name,
               got, exp);
      valueErrors++;
    end
  endtask

  task automatic compareEntry(input vecRowT row);
    checkField("trapCause", trapCause, row.trap);
    checkField("nextPc", nextPc, row.nextPc);
    checkField("rdWrite", rdWrite, row.rdWrite);
    checkField("memRead", memRead, row.memRw[1]);
    checkField("memWrite", memWrite, row.memRw[0]);
    if (row.rdWrite) begin
      checkField("rdAddr", rdAddr, row.rd);
      checkField("rdData", rdData, row.rdData);
    end
    if (row.memRw != 2'b00) begin
      checkField("memAddr", memAddr, row.memAddr);
      checkField("memSize", memSize, row.memSize);
    end
    if (row.memRw == 2'b01) checkField("storeData", storeData, row.rs2);
  endtask

  always @(negedge clk) begin
    if (reset) begin
      cycle       = 0;
      lastLow     = 0;
      seenCount   = 0;
      valueErrors = 0;
      flowErrors  = 0;
      prevHold    = 1'b0;
      inCycles.delete();
    end else begin
      cycle++;
      if (!outReady) lastLow = cycle;
      if (prevHold && (!outValid || outBus !== prevOut)) begin
        $display("ERROR %0t: outputs changed while stalled by outReady", $time);
        flowErrors++;
      end
      if (inValid && inReady) inCycles.push_back(cycle);
      if (outValid && outReady) begin
        if (seenCount >= NUM_VEC) begin
          $display("extra result at %0t ns beyond the end of the table", $time);
          flowErrors++;
        end else if (inCycles.size() == 0) begin
          $display("result at %0t ns has no matching input transfer", $time);
          flowErrors++;
        end else begin
          compareEntry(vecTable[seenCount]);
          startCycle = inCycles.pop_front();
          if (lastLow <= startCycle && cycle != startCycle + 2) begin
            $display("ERROR %0t: entry %0d latency %0d cycles, expected 2", $time, seenCount,
                     cycle - startCycle);
            flowErrors++;
          end
          seenCount++;
        end
      end
      prevHold = outValid && !outReady;
      prevOut  = outBus;
    end
  end

endmodule

//--- tb/rvExecUnitTb.sv
// Testbench for rvExecUnit: table driven, checker module does all comparing.
// First BURST_LEN entries go back to back with outReady high, the rest with
// random gaps and random back-pressure.

`timescale 1ns/1ps

module rvExecUnitTb import rvExecPkg::*; ();

  `include "rvExecVectors.svh"

  localparam int BURST_LEN      = 12;
  localparam int TIMEOUT_CYCLES = NUM_VEC * 20 + 100;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  inValid;
  logic                  inReady;
  logic [XLEN-1:0]       instWord;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       rs1Data;
  logic [XLEN-1:0]       rs2Data;
  logic                  outValid;
  logic                  outReady;
  logic [REG_ADDR_W-1:0] rdAddr;
  logic                  rdWrite;
  logic [XLEN-1:0]       rdData;
  logic [XLEN-1:0]       nextPc;
  logic                  memRead;
  logic                  memWrite;
  logic [XLEN-1:0]       memAddr;
  memSizeT               memSize;
  logic [XLEN-1:0]       storeData;
  trapCauseT             trapCause;
  int                    seenCount;
  int                    valueErrors;
  int                    flowErrors;
  logic                  burst;

  always #5 clk = ~clk;

  rvExecUnit rvExecUnit_inst (
    .clk       (clk),
    .reset     (reset),
    .inValid   (inValid),
    .inReady   (inReady),
    .instWord  (instWord),
    .pc        (pc),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data),
    .outValid  (outValid),
    .outReady  (outReady),
    .rdAddr    (rdAddr),
    .rdWrite   (rdWrite),
    .rdData    (rdData),
    .nextPc    (nextPc),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .memAddr   (memAddr),
    .memSize   (memSize),
    .storeData (storeData),
    .trapCause (trapCause)
  );

  rvExecChecker rvExecChecker_inst (
    .clk         (clk),
    .reset       (reset),
    .inValid     (inValid),
    .inReady     (inReady),
    .outValid    (outValid),
    .outReady    (outReady),
    .rdAddr      (rdAddr),
    .rdWrite     (rdWrite),
    .rdData      (rdData),
    .nextPc      (nextPc),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .memAddr     (memAddr),
    .memSize     (memSize),
    .storeData   (storeData),
    .trapCause   (trapCause),
    .seenCount   (seenCount),
    .valueErrors (valueErrors),
    .flowErrors  (flowErrors)
  );

  // random stall on the output side, 1 ns after each rising edge
  task automatic driveOutReady();
    forever begin
      @(posedge clk);
      #1;
      if (burst) outReady = 1'b1;
      else outReady = ($urandom_range(0, 3) != 0);
    end
  endtask

  task automatic idleGap(input int cycles);
    inValid = 1'b0;
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  // hold the entry until inReady is seen before a rising edge
  task automatic driveEntry(input int idx);
    bit took;
    inValid  = 1'b1;
    instWord = vecTable[idx].instWord;
    pc       = vecTable[idx].pc;
    rs1Data  = vecTable[idx].rs1;
    rs2Data  = vecTable[idx].rs2;
    took     = 1'b0;
    while (!took) begin
      @(negedge clk);
      took = inReady;
      @(posedge clk);
      #1;
    end
    inValid = 1'b0;
  endtask

  initial begin : stimulus
    void'($urandom(80733));
    reset    = 1'b1;
    inValid  = 1'b0;
    instWord = '0;
    pc       = '0;
    rs1Data  = '0;
    rs2Data  = '0;
    outReady = 1'b0;
    burst    = 1'b1;
    fork
      driveOutReady();
    join_none
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < NUM_VEC; i++) begin
      if (i == BURST_LEN) burst = 1'b0;
      if (!burst) idleGap($urandom_range(0, 3));
      driveEntry(i);
    end
  end

  initial begin : finishRun
    int cycles;
    bit hung;
    cycles = 0;
    while (seenCount < NUM_VEC && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    hung = (seenCount < NUM_VEC);
    repeat (4) @(posedge clk); // room for a stray extra result
    if (hung) begin
      $display("timeout after %0d cycles, only %0d of %0d results came out", cycles,
               seenCount, NUM_VEC);
    end
    $display("error counts: value %0d, flow %0d, timeout %0d", valueErrors, flowErrors,
             hung);
    if (!hung && valueErrors == 0 && flowErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+tb
common/rvExecPkg.sv
hw/execute/aluCore.sv
hw/execute/executeStage.sv
hw/decode/instDecoder.sv
hw/rvExecUnit.sv
tb/rvExecChecker.sv
tb/rvExecUnitTb.sv

//--- Bender.yml
package:
  name: rv_exec_unit

sources:
  - common/rvExecPkg.sv
  - hw/execute/aluCore.sv
  - hw/execute/executeStage.sv
  - hw/decode/instDecoder.sv
  - hw/rvExecUnit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/rvExecChecker.sv
      - tb/rvExecUnitTb.sv
